//--- files.f
logic/mcuBusPkg.sv
logic/microControllerCsr.sv
logic/busFabric.sv
logic/peripheralRegBank.sv
logic/mcuBusSubsystem.sv
testbench/mcuBusTb.sv

//--- runSim.sh
#!/bin/sh
# Build the MCU bus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mcuBusTb -f files.f -o mcuBusSim \
	&& ./obj_dir/mcuBusSim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& { echo "runSim: run passed"; exit 0; } \
	|| { echo "runSim: run failed"; exit 1; }

//--- testbench/mcuBusTb.sv
/*
 * MCU bus subsystem testbench
 * Walks a table of CSR writes and reads through the processor port.
 * Expected read values come from a reference model of the CSR,
 * the bank contents and the bank busy window.
 */
`default_nettype none

module mcuBusTb;

	localparam int clkPeriod    = 4;
	localparam int resetCycles  = 10;
	localparam int settleCycles = 4;
	localparam bit opWrite      = 1'b0;
	localparam bit opRead       = 1'b1;

	logic               iSysClk = 1'b0;
	logic               rstN;
	mcuBusPkg::csrAdrs  adrs;
	mcuBusPkg::dataWord wd;
	logic               cke;
	mcuBusPkg::dataWord rd;

	// Operation table, one entry per row
	bit                 opKind  [$];
	mcuBusPkg::csrAdrs  opAdrs  [$];
	mcuBusPkg::dataWord opData  [$];
	mcuBusPkg::dataWord opExp   [$];
	int                 opDelay [$];
	bit                 tableReady = 1'b0;
	int                 seed = 32'hda02;

	// ----------------------------------------------------------------------
	// Reference model state
	// ----------------------------------------------------------------------
	// Model time in cycles, counted from the first table row
	int                 modelTime;
	mcuBusPkg::dataWord modelWd;
	mcuBusPkg::busAdrs  modelAdrs;
	mcuBusPkg::dataWord modelMem [mcuBusPkg::busBlockCount][16];
	// Clock edge of the last accepted write per bank
	int                 lastAccept [mcuBusPkg::busBlockCount];

	mcuBusSubsystem u_dut (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.adrs    (adrs),
		.wd      (wd),
		.cke     (cke),
		.rd      (rd)
	);

	always
	begin
		#2 iSysClk = ~iSysClk;
	end

	// Write row at cycle t, bank strobe lands on edge t+2
	task automatic applyWrite(input mcuBusPkg::csrAdrs a, input mcuBusPkg::dataWord d,
		input int t);
		int blk;
		int idx;
		blk = int'(modelAdrs[mcuBusPkg::blockSelLsb +: 2]);
		idx = int'(modelAdrs[mcuBusPkg::regIdxLsb +: 4]);
		if (a == mcuBusPkg::csrBusWdAdrs)
			modelWd = d;
		else if (a == mcuBusPkg::csrBusAdrsAdrs)
			modelAdrs = d[15:0];
		else if (a == mcuBusPkg::csrBusWEdAdrs && d[0])
		begin
			// Dropped while the bank is still busy
			if (t + 2 > lastAccept[blk] + mcuBusPkg::bankBusyCycles)
			begin
				modelMem[blk][idx] = modelWd;
				lastAccept[blk] = t + 2;
			end
		end
	endtask

	// Read row at cycle r, rd checked at r+4 shows bank state after edge r+2
	function automatic mcuBusPkg::dataWord expectRead(input mcuBusPkg::csrAdrs a, input int r);
		mcuBusPkg::dataWord v;
		int blk;
		int idx;
		v = '0;
		blk = int'(modelAdrs[mcuBusPkg::blockSelLsb +: 2]);
		idx = int'(modelAdrs[mcuBusPkg::regIdxLsb +: 4]);
		if (a == mcuBusPkg::csrBusWdAdrs)
			v = modelWd;
		else if (a == mcuBusPkg::csrBusAdrsAdrs)
			v = {16'h0, modelAdrs};
		else if (a == mcuBusPkg::csrBusRdAdrs)
			v = modelMem[blk][idx];
		else if (a == mcuBusPkg::csrBusREdAdrs)
		begin
			for (int b = 0; b < mcuBusPkg::busBlockCount; b++)
			begin
				if (!(r + 2 >= lastAccept[b] &&
					r + 2 < lastAccept[b] + mcuBusPkg::bankBusyCycles))
					v[b] = 1'b1;
			end
		end
		return v;
	endfunction

	task automatic addRow(input bit kind, input mcuBusPkg::csrAdrs a,
		input mcuBusPkg::dataWord d, input int delay);
		mcuBusPkg::dataWord expVal;
		expVal = '0;
		if (kind == opWrite)
		begin
			applyWrite(a, d, modelTime);
			modelTime = modelTime + 1 + delay;
		end
		else
		begin
			expVal = expectRead(a, modelTime);
			modelTime = modelTime + settleCycles + delay;
		end
		opKind.push_back(kind);
		opAdrs.push_back(a);
		opData.push_back(d);
		opExp.push_back(expVal);
		opDelay.push_back(delay);
	endtask

	// Data, address, then enable
	task automatic busWrite(input int blk, input int idx, input mcuBusPkg::dataWord d,
		input int delay);
		addRow(opWrite, mcuBusPkg::csrBusWdAdrs, d, 0);
		addRow(opWrite, mcuBusPkg::csrBusAdrsAdrs, 32'((blk << 8) | (idx << 2)), 0);
		addRow(opWrite, mcuBusPkg::csrBusWEdAdrs, 32'h1, delay);
	endtask

	task automatic readBank(input int blk, input int idx);
		addRow(opWrite, mcuBusPkg::csrBusAdrsAdrs, 32'((blk << 8) | (idx << 2)), 0);
		addRow(opRead, mcuBusPkg::csrBusRdAdrs, '0, 0);
	endtask

	task automatic buildTable();
		int idxList [8];
		mcuBusPkg::dataWord first;
		modelTime = 0;
		modelWd = '0;
		modelAdrs = '0;
		for (int b = 0; b < mcuBusPkg::busBlockCount; b++)
		begin
			lastAccept[b] = -100;
			for (int w = 0; w < 16; w++)
				modelMem[b][w] = '0;
		end
		// Reset values at every CSR address
		for (int a = 0; a <= 16; a += 4)
			addRow(opRead, 8'(a), '0, 0);
		// Manual register readback, address truncated to 16 bits
		addRow(opWrite, mcuBusPkg::csrBusWdAdrs, $random(seed), 0);
		addRow(opRead, mcuBusPkg::csrBusWdAdrs, '0, 0);
		addRow(opWrite, mcuBusPkg::csrBusAdrsAdrs, 32'hABCD_0314, 0);
		addRow(opRead, mcuBusPkg::csrBusAdrsAdrs, '0, 0);
		// Random words in all four banks
		for (int k = 0; k < 8; k++)
		begin
			idxList[k] = $random(seed) & 15;
			busWrite(k % 4, idxList[k], $random(seed), 4);
		end
		// Enable auto-clear, then an enable write with bit 0 clear
		addRow(opRead, mcuBusPkg::csrBusWEdAdrs, '0, 0);
		addRow(opWrite, mcuBusPkg::csrBusWdAdrs, $random(seed), 0);
		addRow(opWrite, mcuBusPkg::csrBusWEdAdrs, 32'h2, 0);
		for (int k = 0; k < 8; k++)
			readBank(k % 4, idxList[k]);
		// Ready drops right after a write, back after the busy window
		busWrite(2, 7, $random(seed), 0);
		addRow(opRead, mcuBusPkg::csrBusREdAdrs, '0, 0);
		addRow(opRead, mcuBusPkg::csrBusREdAdrs, '0, 0);
		// Write to a busy bank is dropped, other bank takes it
		first = $random(seed);
		busWrite(1, 3, first, 0);
		addRow(opWrite, mcuBusPkg::csrBusWdAdrs, ~first, 0);
		addRow(opWrite, mcuBusPkg::csrBusWEdAdrs, 32'h1, 4);
		readBank(1, 3);
		busWrite(3, 3, ~first, 4);
		readBank(3, 3);
	endtask

	task automatic checkEqual(input string name, input mcuBusPkg::dataWord got,
		input mcuBusPkg::dataWord exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------------------------------------
	// Watchdog
	// ----------------------------------------------------------------------
	initial
	begin
		wait (tableReady);
		#((opKind.size() * 20 + resetCycles) * clkPeriod);
		$display("Watchdog: the run did not finish in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	initial
	begin
		rstN = 1'b0;
		adrs = '0;
		wd = '0;
		cke = 1'b0;
		buildTable();
		tableReady = 1'b1;
		repeat (resetCycles) @(negedge iSysClk);
		rstN = 1'b1;
		@(negedge iSysClk);
		for (int i = 0; i < opKind.size(); i++)
		begin
			adrs = opAdrs[i];
			if (opKind[i] == opWrite)
			begin
				wd = opData[i];
				cke = 1'b1;
				@(negedge iSysClk);
				cke = 1'b0;
			end
			else
			begin
				repeat (settleCycles) @(negedge iSysClk);
				checkEqual($sformatf("rd@%02h", opAdrs[i]), rd, opExp[i]);
			end
			repeat (opDelay[i]) @(negedge iSysClk);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/mcuBusSubsystem.sv
/*
 * MCU bus subsystem top
 * Processor CSR mastering a bus fabric with four peripheral banks
 */
`default_nettype none

module mcuBusSubsystem (
	input  wire                iSysClk,
	input  wire                rstN,
	input  mcuBusPkg::csrAdrs  adrs,
	input  mcuBusPkg::dataWord wd,
	input  wire                cke,
	output mcuBusPkg::dataWord rd
);

	// CSR to fabric
	mcuBusPkg::dataWord busWd;
	mcuBusPkg::busAdrs  busAdrs;
	logic               busWEd;
	// Fabric and banks back to CSR
	mcuBusPkg::dataWord busRd;
	mcuBusPkg::readyVec busREd;
	// Fabric to banks
	mcuBusPkg::readyVec                  bankWe;
	logic [mcuBusPkg::regIndexWidth-1:0] regIdx;
	mcuBusPkg::dataWord                  bankRd [mcuBusPkg::busBlockCount];

	microControllerCsr u_csr (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.adrs    (adrs),
		.wd      (wd),
		.cke     (cke),
		.rd      (rd),
		.busWd   (busWd),
		.busAdrs (busAdrs),
		.busWEd  (busWEd),
		.busRd   (busRd),
		.busREd  (busREd)
	);

	busFabric u_fabric (
		.busAdrs (busAdrs),
		.busWEd  (busWEd),
		.bankWe  (bankWe),
		.regIdx  (regIdx),
		.bankRd  (bankRd),
		.busRd   (busRd)
	);

	// ----------------------------------------------------------------------
	// Peripheral banks, shared index and write data
	// ----------------------------------------------------------------------
	for (genvar g = 0; g < mcuBusPkg::busBlockCount; g++)
	begin : gBank
		peripheralRegBank u_bank (
			.iSysClk (iSysClk),
			.rstN    (rstN),
			.we      (bankWe[g]),
			.regIdx  (regIdx),
			.wd      (busWd),
			.rdData  (bankRd[g]),
			.ready   (busREd[g])
		);
	end

endmodule

`default_nettype wire

//--- logic/peripheralRegBank.sv
/*
 * Peripheral register bank
 * Sixteen data words with a registered read port. An accepted write
 * holds the bank busy for a fixed time; writes while busy are dropped.
 */
`default_nettype none

module peripheralRegBank (
	input  wire                                iSysClk,
	input  wire                                rstN,
	input  wire                                we,
	input  wire [mcuBusPkg::regIndexWidth-1:0] regIdx,
	input  mcuBusPkg::dataWord                 wd,
	output mcuBusPkg::dataWord                 rdData,
	output logic                               ready
);

	localparam int wordCount = 2 ** mcuBusPkg::regIndexWidth;

	// Register file
	mcuBusPkg::dataWord regFile [wordCount];

	// Busy tracking
	mcuBusPkg::bankState state;
	logic [mcuBusPkg::bankCntWidth-1:0] busyCnt;
	logic accept;

	// Write only lands while idle
	assign accept = we && (state == mcuBusPkg::bankIdle);

	// ----------------------------------------------------------------------
	// Busy FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state   <= mcuBusPkg::bankIdle;
			busyCnt <= '0;
		end
		else
		begin
			case (state)
				mcuBusPkg::bankIdle:
				begin
					if (accept)
					begin
						state   <= mcuBusPkg::bankBusy;
						// Counts down to zero over the busy window
						busyCnt <= mcuBusPkg::bankCntWidth'(mcuBusPkg::bankBusyCycles - 1);
					end
				end
				mcuBusPkg::bankBusy:
				begin
					if (busyCnt == '0)
						state <= mcuBusPkg::bankIdle;
					else
						busyCnt <= busyCnt - 1'b1;
				end
				default: state <= mcuBusPkg::bankIdle;
			endcase
		end
	end

	assign ready = (state == mcuBusPkg::bankIdle);

	// ----------------------------------------------------------------------
	// Storage and read port
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < wordCount; i++)
				regFile[i] <= '0;
			rdData <= '0;
		end
		else
		begin
			if (accept)
				regFile[regIdx] <= wd;
			// Same-cycle write shows the old word
			rdData <= regFile[regIdx];
		end
	end

	// Still busy in the last cycle of the window
	assert property (@(posedge iSysClk) disable iff (!rstN)
		$past(accept, mcuBusPkg::bankBusyCycles) |-> !ready)
		else $error("bank ready returned before the busy window ended");

	// Ready again right after the window
	assert property (@(posedge iSysClk) disable iff (!rstN)
		$past(accept, mcuBusPkg::bankBusyCycles + 1) |-> ready)
		else $error("bank still busy after the busy window");

endmodule

`default_nettype wire

//--- logic/busFabric.sv
/*
 * Bus fabric
 * Decodes the block index of the bus address, steers the write
 * enable to a single bank and returns that bank's read word
 */
`default_nettype none

module busFabric (
	input  mcuBusPkg::busAdrs                 busAdrs,
	input  wire                               busWEd,
	output mcuBusPkg::readyVec                bankWe,
	output logic [mcuBusPkg::regIndexWidth-1:0] regIdx,
	input  mcuBusPkg::dataWord                bankRd [mcuBusPkg::busBlockCount],
	output mcuBusPkg::dataWord                busRd
);

	// Addressed bank
	logic [mcuBusPkg::blockSelWidth-1:0] blockIdx;

	// ----------------------------------------------------------------------
	// Address slicing
	// ----------------------------------------------------------------------
	assign blockIdx = busAdrs[mcuBusPkg::blockSelLsb +: mcuBusPkg::blockSelWidth];
	// Word index sits above the byte offset
	assign regIdx   = busAdrs[mcuBusPkg::regIdxLsb +: mcuBusPkg::regIndexWidth];

	// ----------------------------------------------------------------------
	// Write strobe decode
	// ----------------------------------------------------------------------
	always_comb
	begin
		bankWe = '0;
		for (int i = 0; i < mcuBusPkg::busBlockCount; i++)
		begin
			// Only the addressed bank sees the enable
			if (blockIdx == i[mcuBusPkg::blockSelWidth-1:0])
				bankWe[i] = busWEd;
		end
	end

	// ----------------------------------------------------------------------
	// Read data return
	// ----------------------------------------------------------------------
	// Registered word of the addressed bank
	assign busRd = bankRd[blockIdx];

endmodule

`default_nettype wire

//--- logic/microControllerCsr.sv
/*
 * Processor CSR block and bus master
 * Manual registers are loaded by the processor strobe and drive the bus.
 * Auto registers capture the bus read word and ready flags each cycle.
 * The bus write enable is a single-cycle pulse.
 */
`default_nettype none

module microControllerCsr (
	input  wire                   iSysClk,
	input  wire                   rstN,
	// Processor port
	input  mcuBusPkg::csrAdrs     adrs,
	input  mcuBusPkg::dataWord    wd,
	input  wire                   cke,
	output mcuBusPkg::dataWord    rd,
	// Bus master side
	output mcuBusPkg::dataWord    busWd,
	output mcuBusPkg::busAdrs     busAdrs,
	output logic                  busWEd,
	// Bus return side
	input  mcuBusPkg::dataWord    busRd,
	input  mcuBusPkg::readyVec    busREd
);

	// Auto registers
	mcuBusPkg::dataWord autoRd;
	mcuBusPkg::readyVec autoReady;

	// Strobe hits per manual register
	logic hitWd;
	logic hitAdrs;
	logic hitWEd;

	assign hitWd   = cke && (adrs == mcuBusPkg::csrBusWdAdrs);
	assign hitAdrs = cke && (adrs == mcuBusPkg::csrBusAdrsAdrs);
	assign hitWEd  = cke && (adrs == mcuBusPkg::csrBusWEdAdrs);

	// ----------------------------------------------------------------------
	// Manual registers
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busWd   <= '0;
			busAdrs <= '0;
			busWEd  <= 1'b0;
		end
		else
		begin
			if (hitWd)
				busWd <= wd;
			// Upper bits of wd beyond the bus address are dropped
			if (hitAdrs)
				busAdrs <= wd[mcuBusPkg::busAdrsWidth-1:0];
			// Pulse for one cycle, then back to zero
			busWEd <= hitWEd ? wd[0] : 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// Auto registers
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			autoRd    <= '0;
			autoReady <= '0;
		end
		else
		begin
			// Sampled every cycle, no enable
			autoRd    <= busRd;
			autoReady <= busREd;
		end
	end

	// ----------------------------------------------------------------------
	// Registered read mux
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rd <= '0;
		else
		begin
			case (adrs)
				mcuBusPkg::csrBusWdAdrs:   rd <= busWd;
				mcuBusPkg::csrBusAdrsAdrs: rd <= mcuBusPkg::dataWord'(busAdrs);
				mcuBusPkg::csrBusWEdAdrs:  rd <= mcuBusPkg::dataWord'(busWEd);
				mcuBusPkg::csrBusRdAdrs:   rd <= autoRd;
				mcuBusPkg::csrBusREdAdrs:  rd <= mcuBusPkg::dataWord'(autoReady);
				// Unmapped, hold last value
				default:                   rd <= rd;
			endcase
		end
	end

	// Processor must not issue back-to-back enable writes
	assert property (@(posedge iSysClk) disable iff (!rstN) busWEd |=> !busWEd)
		else $error("busWEd high in two consecutive cycles");

endmodule

`default_nettype wire

//--- logic/mcuBusPkg.sv
/*
 * MCU bus package
 * Widths, CSR address map, bank count and bank busy time shared by
 * the processor CSR, the bus fabric and the peripheral banks
 */
`default_nettype none

package mcuBusPkg;

	// ----------------------------------------------------------------------
	// Widths and counts
	// ----------------------------------------------------------------------
	localparam int dataWidth      = 32;
	localparam int busAdrsWidth   = 16;
	localparam int csrAdrsWidth   = 8;
	// Also the width of the ready vector
	localparam int busBlockCount  = 4;
	// Block index sits at bus address bits 9:8
	localparam int blockSelLsb    = 8;
	localparam int blockSelWidth  = $clog2(busBlockCount);
	// Word index sits at bus address bits 5:2
	localparam int regIdxLsb      = 2;
	localparam int regIndexWidth  = 4;
	// Bank stays busy this long after an accepted write
	localparam int bankBusyCycles = 3;
	localparam int bankCntWidth   = $clog2(bankBusyCycles);

	// ----------------------------------------------------------------------
	// Types
	// ----------------------------------------------------------------------
	typedef logic [dataWidth-1:0]     dataWord;
	typedef logic [busAdrsWidth-1:0]  busAdrs;
	typedef logic [csrAdrsWidth-1:0]  csrAdrs;
	typedef logic [busBlockCount-1:0] readyVec;

	typedef enum logic {
		bankIdle = 1'b0,
		bankBusy = 1'b1
	} bankState;

	// CSR map seen by the processor
	localparam csrAdrs csrBusWdAdrs   = 8'h00;
	localparam csrAdrs csrBusAdrsAdrs = 8'h04;
	localparam csrAdrs csrBusWEdAdrs  = 8'h08;
	localparam csrAdrs csrBusRdAdrs   = 8'h0C;
	localparam csrAdrs csrBusREdAdrs  = 8'h10;

endpackage

`default_nettype wire
